// File: common/mac6_width_pkg.sv
`default_nettype none

package mac6_width_pkg;

    // ----------------------------------------
    // operand and result sizes
    // ----------------------------------------
    localparam int op_w = 6;  // a and b
    localparam int acc_w = 12;
    localparam int res_w = 13;

    // add modes produce one bit more than the operands
    localparam int sum_w = op_w + 1;

    // ----------------------------------------
    // booth recoding
    // ----------------------------------------
    localparam int pp_rows = op_w / 2;  // radix 4

endpackage

`default_nettype wire

// File: common/mac6_mode_pkg.sv
`default_nettype none

package mac6_mode_pkg;

    typedef enum logic [1:0] {
        MODE_MUL_ADD = 2'd0,
        MODE_MUL_SUB = 2'd1,
        MODE_ADD     = 2'd2,
        MODE_SUB     = 2'd3
    } mac_mode_e;

    // second operand is negated
    function automatic logic mode_is_sub(input mac_mode_e mode);
        logic [1:0] bits;
        bits = mode;
        return bits[0];
    endfunction

    // result taken from the 7-bit adder
    function automatic logic mode_is_add_path(input mac_mode_e mode);
        logic [1:0] bits;
        bits = mode;
        return bits[1];
    endfunction

endpackage

`default_nettype wire

// File: logic/han_carlson_adder.sv
`timescale 1ns/1ps
`default_nettype none

module han_carlson_adder #(
    parameter int width = mac6_width_pkg::res_w
) (
    input  logic [width-1:0] a_i,
    input  logic [width-1:0] b_i,
    input  logic             c_i,
    output logic [width-1:0] sum_o
);

    // odd bits need a span of at least width
    localparam int stages = $clog2(width);

    logic [width-1:0] p_bit;
    logic [width-1:0] g_bit;
    logic [width-1:0] g_lvl [0:stages];
    logic [width-1:0] p_lvl [0:stages];
    logic [width-1:0] g_all;

    assign p_bit = a_i ^ b_i;

    always_comb begin
        g_bit    = a_i & b_i;
        g_bit[0] = (a_i[0] & b_i[0]) | (p_bit[0] & c_i);  // carry in folded here
    end

    // ----------------------------------------
    // odd bit prefix tree
    // ----------------------------------------
    // level 1 pairs each odd bit with its even neighbour,
    // later levels are kogge-stone over odd bits only
    always_comb begin
        g_lvl[0] = g_bit;
        p_lvl[0] = p_bit;
        for (int k = 1; k <= stages; k++) begin
            g_lvl[k] = g_lvl[k-1];
            p_lvl[k] = p_lvl[k-1];
            for (int i = 1; i < width; i += 2) begin
                if (i >= (1 << (k - 1))) begin
                    g_lvl[k][i] = g_lvl[k-1][i]
                                | (p_lvl[k-1][i] & g_lvl[k-1][i - (1 << (k - 1))]);
                    p_lvl[k][i] = p_lvl[k-1][i] & p_lvl[k-1][i - (1 << (k - 1))];
                end
            end
        end
    end

    // ----------------------------------------
    // even bits in one last stage
    // ----------------------------------------
    always_comb begin
        g_all = g_lvl[stages];
        for (int i = 2; i < width; i += 2) begin
            g_all[i] = g_lvl[stages][i] | (p_lvl[stages][i] & g_lvl[stages][i-1]);
        end
    end

    // carry into bit i is group generate of bits below
    assign sum_o = p_bit ^ {g_all[width-2:0], c_i};

endmodule

`default_nettype wire

// File: mult/booth_pp_gen.sv
`timescale 1ns/1ps
`default_nettype none

module booth_pp_gen (
    input  logic signed [mac6_width_pkg::op_w-1:0]                   a_i,
    input  logic signed [mac6_width_pkg::op_w-1:0]                   b_i,
    output logic [mac6_width_pkg::pp_rows-1:0][mac6_width_pkg::op_w:0] pp_o,
    output logic [mac6_width_pkg::pp_rows-1:0]                       neg_o
);
    import mac6_width_pkg::*;

    logic signed [op_w:0] a_ext;
    logic [op_w:0]        a_dbl;
    logic [op_w:0]        b_pad;
    logic [pp_rows-1:0]   sel_one;
    logic [pp_rows-1:0]   sel_two;
    logic [pp_rows-1:0]   neg;

    assign a_ext = a_i;  // sign extend by one bit
    assign a_dbl = {a_ext[op_w-1:0], 1'b0};

    // implied zero below the lsb of b
    assign b_pad = {b_i, 1'b0};

    // ----------------------------------------
    // recode overlapping triplets of b
    // ----------------------------------------
    always_comb begin
        for (int i = 0; i < pp_rows; i++) begin
            sel_one[i] = b_pad[2*i+1] ^ b_pad[2*i];
            // 011 or 100
            sel_two[i] = (~b_pad[2*i+2] & b_pad[2*i+1] & b_pad[2*i])
                       | (b_pad[2*i+2] & ~b_pad[2*i+1] & ~b_pad[2*i]);
            neg[i] = b_pad[2*i+2];  // msb of triplet
        end
    end

    // ----------------------------------------
    // partial product select
    // ----------------------------------------
    always_comb begin
        for (int i = 0; i < pp_rows; i++) begin
            for (int j = 0; j <= op_w; j++) begin
                pp_o[i][j] = ((a_ext[j] & sel_one[i]) | (a_dbl[j] & sel_two[i])) ^ neg[i];
            end
        end
    end

    // +1 of the two's complement is added later
    assign neg_o = neg;

endmodule

`default_nettype wire

// File: mult/booth_mac.sv
`timescale 1ns/1ps
`default_nettype none

module booth_mac (
    input  logic signed [mac6_width_pkg::op_w-1:0]  a_i,
    input  logic signed [mac6_width_pkg::op_w-1:0]  b_i,
    input  logic signed [mac6_width_pkg::acc_w-1:0] acc_i,
    input  mac6_mode_pkg::mac_mode_e                 mode_i,
    output logic signed [mac6_width_pkg::res_w-1:0] mul_res_o
);
    import mac6_width_pkg::*;
    import mac6_mode_pkg::*;

    logic [pp_rows-1:0][op_w:0] pp;
    logic [pp_rows-1:0]         neg;
    logic                       sub;

    logic signed [res_w-1:0] pp_sx [pp_rows];
    logic [res_w-1:0]        pp_row [pp_rows];
    logic [res_w-1:0]        neg_row;
    logic signed [res_w-1:0] acc_sx;
    logic [res_w-1:0]        acc_row;
    logic [res_w-1:0]        cin_row;

    logic [res_w-1:0] sum_a, carry_a;
    logic [res_w-1:0] sum_b, carry_b;
    logic [res_w-1:0] sum_c, carry_c;
    logic [res_w-1:0] sum_d, carry_d;

    function automatic logic [res_w-1:0] csa_sum(input logic [res_w-1:0] x,
                                                 input logic [res_w-1:0] y,
                                                 input logic [res_w-1:0] z);
        return x ^ y ^ z;
    endfunction

    function automatic logic [res_w-1:0] csa_carry(input logic [res_w-1:0] x,
                                                   input logic [res_w-1:0] y,
                                                   input logic [res_w-1:0] z);
        logic [res_w-1:0] maj;
        maj = (x & y) | (y & z) | (x & z);
        return {maj[res_w-2:0], 1'b0};  // weight moves up one bit
    endfunction

    assign sub = mode_is_sub(mode_i);

    booth_pp_gen i_pp_gen (
        .a_i   (a_i),
        .b_i   (b_i),
        .pp_o  (pp),
        .neg_o (neg)
    );

    // ----------------------------------------
    // six rows into the tree
    // ----------------------------------------
    always_comb begin
        neg_row = '0;
        for (int i = 0; i < pp_rows; i++) begin
            pp_sx[i]       = $signed(pp[i]);
            pp_row[i]      = pp_sx[i] << (2 * i);  // radix 4 weight
            neg_row[2 * i] = neg[i];
        end
    end

    assign acc_sx  = acc_i;
    assign acc_row = acc_sx ^ {res_w{sub}};  // ~acc for subtract
    assign cin_row = {{(res_w - 1){1'b0}}, sub};

    // ----------------------------------------
    // carry save reduction 6 -> 4 -> 3 -> 2
    // ----------------------------------------
    assign sum_a   = csa_sum(pp_row[0], pp_row[1], pp_row[2]);
    assign carry_a = csa_carry(pp_row[0], pp_row[1], pp_row[2]);
    assign sum_b   = csa_sum(neg_row, acc_row, cin_row);
    assign carry_b = csa_carry(neg_row, acc_row, cin_row);

    assign sum_c   = csa_sum(sum_a, carry_a, sum_b);
    assign carry_c = csa_carry(sum_a, carry_a, sum_b);
    assign sum_d   = csa_sum(sum_c, carry_c, carry_b);
    assign carry_d = csa_carry(sum_c, carry_c, carry_b);

    han_carlson_adder #(
        .width (res_w)
    ) i_final_add (
        .a_i   (sum_d),
        .b_i   (carry_d),
        .c_i   (1'b0),
        .sum_o (mul_res_o)
    );

endmodule

`default_nettype wire

// File: logic/add_sub_unit.sv
`timescale 1ns/1ps
`default_nettype none

module add_sub_unit (
    input  logic signed [mac6_width_pkg::op_w-1:0]  a_i,
    input  logic signed [mac6_width_pkg::op_w-1:0]  b_i,
    input  mac6_mode_pkg::mac_mode_e                 mode_i,
    output logic signed [mac6_width_pkg::sum_w-1:0] sum_res_o
);
    import mac6_width_pkg::*;
    import mac6_mode_pkg::*;

    logic                    sub;
    logic signed [sum_w-1:0] a_ext;
    logic signed [sum_w-1:0] b_ext;
    logic [sum_w-1:0]        b_inv;

    assign sub = mode_is_sub(mode_i);

    // both operands widened so the sum cannot overflow
    assign a_ext = a_i;
    assign b_ext = b_i;
    assign b_inv = b_ext ^ {sum_w{sub}};  // ~b, +1 through carry in

    han_carlson_adder #(
        .width (sum_w)
    ) i_adder (
        .a_i   (a_ext),
        .b_i   (b_inv),
        .c_i   (sub),
        .sum_o (sum_res_o)
    );

endmodule

`default_nettype wire

// File: logic/result_select.sv
`timescale 1ns/1ps
`default_nettype none

module result_select (
    input  logic                                    clk,
    input  logic                                    reset_i,
    input  mac6_mode_pkg::mac_mode_e                 mode_i,
    input  logic signed [mac6_width_pkg::res_w-1:0] mul_res_i,
    input  logic signed [mac6_width_pkg::sum_w-1:0] sum_res_i,
    output logic signed [mac6_width_pkg::res_w-1:0] result_o
);
    import mac6_width_pkg::*;
    import mac6_mode_pkg::*;

    logic signed [res_w-1:0] sum_ext;
    logic signed [res_w-1:0] sel_res;

    assign sum_ext = sum_res_i;  // sign extend 7 -> 13

    // ----------------------------------------
    // path select
    // ----------------------------------------
    always_comb begin
        if (mode_is_add_path(mode_i)) begin
            sel_res = sum_ext;
        end else begin
            sel_res = mul_res_i;
        end
    end

    // single output stage
    always_ff @(posedge clk) begin
        if (reset_i) begin
            result_o <= '0;
        end else begin
            result_o <= sel_res;
        end
    end

endmodule

`default_nettype wire

// File: logic/mac6_top.sv
`timescale 1ns/1ps
`default_nettype none

module mac6_top (
    input  logic                                    clk,
    input  logic                                    reset_i,
    input  logic signed [mac6_width_pkg::op_w-1:0]  a_i,
    input  logic signed [mac6_width_pkg::op_w-1:0]  b_i,
    input  logic signed [mac6_width_pkg::acc_w-1:0] acc_i,
    input  mac6_mode_pkg::mac_mode_e                 mode_i,
    output logic signed [mac6_width_pkg::res_w-1:0] result_o
);
    import mac6_width_pkg::*;

    logic signed [res_w-1:0] mul_res;  // modes 0 and 1
    logic signed [sum_w-1:0] sum_res;  // modes 2 and 3

    booth_mac i_booth_mac (
        .a_i       (a_i),
        .b_i       (b_i),
        .acc_i     (acc_i),
        .mode_i    (mode_i),
        .mul_res_o (mul_res)
    );

    add_sub_unit i_add_sub (
        .a_i       (a_i),
        .b_i       (b_i),
        .mode_i    (mode_i),
        .sum_res_o (sum_res)
    );

    result_select i_result_select (
        .clk       (clk),
        .reset_i   (reset_i),
        .mode_i    (mode_i),
        .mul_res_i (mul_res),
        .sum_res_i (sum_res),
        .result_o  (result_o)
    );

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic reset_o
);

    localparam int half_period = 20;  // 40 ns clock
    localparam int reset_cycles = 2;

    initial begin
        clk_o = 1'b0;
        forever #(half_period) clk_o = ~clk_o;
    end

    // release on a falling edge, like every other input
    initial begin
        reset_o = 1'b1;
        repeat (reset_cycles) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b0;
    end

endmodule

`default_nettype wire

// File: test/mac6_assert.sv
`timescale 1ns/1ps
`default_nettype none

module mac6_assert (
    input logic                                    clk_i,
    input logic                                    reset_i,
    input mac6_mode_pkg::mac_mode_e                 mode_i,
    input logic signed [mac6_width_pkg::res_w-1:0] result_i
);
    import mac6_width_pkg::*;
    import mac6_mode_pkg::*;

    logic add_mode;

    assign add_mode = (mode_i == MODE_ADD) || (mode_i == MODE_SUB);

    // output register clears on a reset edge
    reset_clears: assert property (@(posedge clk_i) reset_i |=> (result_i == '0))
        else $error("result_o not cleared after reset");

    // 7-bit sum sign extended into the upper bits
    add_sign_ext: assert property (@(posedge clk_i) disable iff (reset_i)
        add_mode |=> (result_i[res_w-1:op_w] == {sum_w{result_i[res_w-1]}}))
        else $error("add result not sign extended");

    no_unknown: assert property (@(posedge clk_i) !reset_i |-> !$isunknown(result_i))
        else $error("result_o unknown after reset");

endmodule

`default_nettype wire

// File: test/tb_mac6.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mac6;
    import mac6_width_pkg::*;
    import mac6_mode_pkg::*;

    localparam int n_random = 400;
    localparam int timeout_cycles = n_random + 100;  // corners, reset and drain fit in 100

    logic                    clk;
    logic                    reset;
    logic signed [op_w-1:0]  a;
    logic signed [op_w-1:0]  b;
    logic signed [acc_w-1:0] acc;
    mac_mode_e               mode;
    logic signed [res_w-1:0] result;

    logic signed [res_w-1:0] expected_q [$];  // one entry per sampled edge
    integer                  seed;
    int                      n_driven = 0;
    int                      n_checked = 0;
    int                      cycle_count = 0;

    tb_clock_gen i_clock_gen (
        .clk_o   (clk),
        .reset_o (reset)
    );

    mac6_top i_dut (
        .clk      (clk),
        .reset_i  (reset),
        .a_i      (a),
        .b_i      (b),
        .acc_i    (acc),
        .mode_i   (mode),
        .result_o (result)
    );

    bind mac6_top mac6_assert i_mac6_assert (
        .clk_i    (clk),
        .reset_i  (reset_i),
        .mode_i   (mode_i),
        .result_i (result_o)
    );

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    function automatic logic signed [res_w-1:0] expected_result(input mac_mode_e m,
                                                                input logic signed [op_w-1:0] x,
                                                                input logic signed [op_w-1:0] y,
                                                                input logic signed [acc_w-1:0] z);
        int                      full;
        logic signed [sum_w-1:0] short_sum;
        full = 0;
        case (m)
            MODE_MUL_ADD: full = int'(x) * int'(y) + int'(z);
            MODE_MUL_SUB: full = int'(x) * int'(y) - int'(z);
            MODE_ADD: begin
                short_sum = sum_w'(int'(x) + int'(y));
                full = int'(short_sum);
            end
            default: begin
                short_sum = sum_w'(int'(x) - int'(y));
                full = int'(short_sum);
            end
        endcase
        return full[res_w-1:0];
    endfunction

    task automatic check_value(input string name,
                               input logic signed [res_w-1:0] expected,
                               input logic signed [res_w-1:0] actual);
        if (actual !== expected) begin
            $display("FAIL t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "result mismatch");
        end
    endtask

    task automatic drive_vector(input mac_mode_e m, input int av, input int bv, input int accv);
        @(negedge clk);
        mode = m;
        a    = av[op_w-1:0];
        b    = bv[op_w-1:0];
        acc  = accv[acc_w-1:0];
        n_driven++;
    endtask

    // expected value captured when the dut samples
    always @(posedge clk) begin
        if (reset) begin
            expected_q.push_back('0);
        end else begin
            expected_q.push_back(expected_result(mode, a, b, acc));
        end
    end

    always @(negedge clk) begin
        if (expected_q.size() > 0) begin
            check_value("result_o", expected_q.pop_front(), result);
            n_checked++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout after %0d cycles, stimulus did not finish", cycle_count);
            $display("RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    initial begin
        mac_mode_e prev_mode;
        mac_mode_e next_mode;
        logic [31:0] rnd;
        int ra;
        int rb;
        int racc;

        seed = 32'h43ce6be9;
        a    = '0;
        b    = '0;
        acc  = '0;
        mode = MODE_MUL_ADD;
        wait (reset == 1'b0);

        drive_vector(MODE_MUL_ADD, -32, -32, 0);
        drive_vector(MODE_MUL_ADD, 31, 31, 0);
        drive_vector(MODE_MUL_ADD, -32, 31, 0);
        drive_vector(MODE_MUL_ADD, 31, -32, 0);
        drive_vector(MODE_MUL_ADD, -32, -32, 2047);
        drive_vector(MODE_MUL_ADD, -32, -32, -2048);
        drive_vector(MODE_MUL_ADD, 31, -32, -2048);
        drive_vector(MODE_MUL_ADD, -32, 31, 2047);
        drive_vector(MODE_MUL_ADD, 0, 0, -2048);
        drive_vector(MODE_MUL_ADD, 1, -1, 2047);
        drive_vector(MODE_MUL_SUB, -32, -32, 0);
        drive_vector(MODE_MUL_SUB, -32, -32, -2048);
        drive_vector(MODE_MUL_SUB, 31, -32, -2048);
        drive_vector(MODE_MUL_SUB, -32, 31, 2047);
        drive_vector(MODE_MUL_SUB, 31, 31, -2048);
        drive_vector(MODE_MUL_SUB, 0, 0, 0);
        drive_vector(MODE_ADD, 31, 31, 0);
        drive_vector(MODE_ADD, -32, -32, 0);
        drive_vector(MODE_ADD, -32, 31, 0);
        drive_vector(MODE_ADD, 0, -1, 0);
        drive_vector(MODE_SUB, -32, 31, 0);
        drive_vector(MODE_SUB, 31, -32, 0);
        drive_vector(MODE_SUB, -32, -32, 0);
        drive_vector(MODE_SUB, 0, 31, 0);

        // random vectors, mode never repeats back to back
        prev_mode = mode;
        for (int i = 0; i < n_random; i++) begin
            rnd = $random(seed);
            next_mode = mac_mode_e'(rnd[1:0]);
            if (next_mode == prev_mode) begin
                next_mode = mac_mode_e'(2'(rnd[1:0] + 2'd1));
            end
            ra   = $random(seed);
            rb   = $random(seed);
            racc = $random(seed);
            drive_vector(next_mode, ra, rb, racc);
            prev_mode = next_mode;
        end

        repeat (2) @(negedge clk);
        #1;
        if (n_checked > n_driven && expected_q.size() == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("run incomplete, %0d results checked for %0d vectors", n_checked, n_driven);
            $display("RESULT: FAIL");
            $fatal(1, "incomplete run");
        end
    end

endmodule

`default_nettype wire

// File: mac6.f
common/mac6_width_pkg.sv
common/mac6_mode_pkg.sv
logic/han_carlson_adder.sv
mult/booth_pp_gen.sv
mult/booth_mac.sv
logic/add_sub_unit.sv
logic/result_select.sv
logic/mac6_top.sv
test/tb_clock_gen.sv
test/mac6_assert.sv
test/tb_mac6.sv

// File: run_sim.sh
#!/bin/sh
# build the mac6 testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mac6 -f mac6.f \
    || { echo "verilator build failed"; exit 1; }

out=$(./obj_dir/Vtb_mac6 2>&1)
echo "$out"

echo "$out" | grep -q "^RESULT: PASS$" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
